// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := nocSwitchTb
FILELIST  := nocSwitch.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(OBJDIR)

// ==== design/flitIntf.sv ====
// Head of one input queue as seen by the switch core
interface flitIntf;

  logic [routerPkg::DATA_W-1:0] headData;
  routerPkg::flitKindT          headKind;
  logic                         notEmpty;
  logic                         pop;       // One-cycle strobe

  modport queue
  (
    output headData,
    output headKind,
    output notEmpty,
    input  pop
  );

  modport sink
  (
    input  headData,
    input  headKind,
    input  notEmpty,
    output pop
  );

  modport monitor
  (
    input  headData,
    input  headKind,
    input  notEmpty
  );

endinterface

// ==== design/inputQueue.sv ====
module inputQueue
#(
  parameter int DEPTH = 8
)
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         wrValid,
  input  logic [routerPkg::DATA_W-1:0] wrData,
  input  routerPkg::flitKindT          wrKind,
  output logic                         full,
  flitIntf.queue                       head
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [routerPkg::DATA_W-1:0] dataMem [DEPTH];
  routerPkg::flitKindT          kindMem [DEPTH];
  logic [PTR_W-1:0]             wrPtr;
  logic [PTR_W-1:0]             rdPtr;
  logic [CNT_W-1:0]             count;
  logic                         notEmpty;
  logic                         doWrite;
  logic                         doRead;

  // Wraps at DEPTH, works for any depth
  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign notEmpty = (count != '0);
  assign full     = (count == CNT_W'(DEPTH));
  assign doWrite  = wrValid && !full; // Writes into a full queue are ignored
  assign doRead   = head.pop && notEmpty;

  // ********************
  // Storage
  // ********************
  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      dataMem[wrPtr] <= wrData;
      kindMem[wrPtr] <= wrKind;
    end
  end

  // ********************
  // Pointers and occupancy
  // ********************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= bump(wrPtr);
      if (doRead)
        rdPtr <= bump(rdPtr);
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Idle or write with pop
      endcase
    end
  end

  assign head.notEmpty = notEmpty;
  assign head.headData = dataMem[rdPtr];
  // Stale slots must not look like a header to the timer
  assign head.headKind = notEmpty ? kindMem[rdPtr] : routerPkg::FLIT_NONE;

endmodule

// ==== design/nocSwitch.sv ====
module nocSwitch
#(
  parameter int DEPTH = 8
)
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         inValid [routerPkg::NUM_PORTS],
  input  logic [routerPkg::DATA_W-1:0] inData  [routerPkg::NUM_PORTS],
  input  routerPkg::flitKindT          inKind  [routerPkg::NUM_PORTS],
  output logic                         inFull  [routerPkg::NUM_PORTS],
  output logic                         outValid,
  output logic [routerPkg::DATA_W-1:0] outData,
  output routerPkg::flitKindT          outKind,
  output routerPkg::portT              outPort
);

  flitIntf             headIf [routerPkg::NUM_PORTS] ();
  routerPkg::arbStateT grant;

  // ********************
  // Input queues
  // ********************
  for (genvar i = 0; i < routerPkg::NUM_PORTS; i++)
  begin : gPort
    inputQueue
    #(
      .DEPTH (DEPTH)
    )
    uQueue
    (
      .clk     (clk),
      .rst     (rst),
      .wrValid (inValid[i]),
      .wrData  (inData[i]),
      .wrKind  (inKind[i]),
      .full    (inFull[i]),
      .head    (headIf[i])
    );
  end

  // ********************
  // Allocation and output
  // ********************
  portArbiter uArbiter
  (
    .clk   (clk),
    .rst   (rst),
    .mon   (headIf),
    .grant (grant)
  );

  switchOutput uOutput
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .src      (headIf),
    .outValid (outValid),
    .outData  (outData),
    .outKind  (outKind),
    .outPort  (outPort)
  );

endmodule

// ==== design/portArbiter.sv ====
module portArbiter
(
  input  logic                clk,
  input  logic                rst,
  flitIntf.monitor            mon [routerPkg::NUM_PORTS],
  output routerPkg::arbStateT grant
);

  routerPkg::arbStateT              state;
  routerPkg::arbStateT              nextState;
  routerPkg::portT                  curPort;
  logic                             busy;
  logic [routerPkg::NUM_PORTS-1:0]  req;
  logic [routerPkg::NUM_PORTS-1:0]  timesUp;
  logic [routerPkg::NUM_PORTS-1:0]  runTimer;

  // ********************
  // Per-port quantum timers
  // ********************
  for (genvar i = 0; i < routerPkg::NUM_PORTS; i++)
  begin : gTimer
    assign req[i] = mon[i].notEmpty;

    portTimer uTimer
    (
      .clk      (clk),
      .rst      (rst),
      .headKind (mon[i].headKind),
      .length   (mon[i].headData[routerPkg::LEN_W-1:0]),
      .run      (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  // ********************
  // Grant FSM
  // ********************
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= routerPkg::ARB_IDLE;
    else
      state <= nextState;
  end

  assign curPort = routerPkg::grantPort(state);
  // Only a legal port state counts as holding a grant
  assign busy    = (state == routerPkg::portGrant(curPort));

  always_comb
  begin
    nextState = routerPkg::ARB_IDLE;
    runTimer  = '0;
    if (!busy)
    begin
      // Fixed order from idle, lowest index wins
      for (int k = routerPkg::NUM_PORTS - 1; k >= 0; k--)
        if (req[k])
          nextState = routerPkg::portGrant(routerPkg::portT'(k));
    end
    else if (req[curPort] && !timesUp[curPort])
    begin
      nextState         = state;
      runTimer[curPort] = 1'b1;
    end
    else
    begin
      // Rotate to first requester after current port
      for (int k = routerPkg::NUM_PORTS - 1; k >= 1; k--)
        if (req[(int'(curPort) + k) % routerPkg::NUM_PORTS])
          nextState = routerPkg::portGrant(
            routerPkg::portT'((int'(curPort) + k) % routerPkg::NUM_PORTS));
    end
  end

  assign grant = state; // One-hot

endmodule

// ==== design/portTimer.sv ====
module portTimer
(
  input  logic                        clk,
  input  logic                        rst,
  input  routerPkg::flitKindT         headKind,
  input  logic [routerPkg::LEN_W-1:0] length,
  input  logic                        run,
  output logic                        timesUp
);

  logic [routerPkg::LEN_W-1:0] quantum; // Length of latest header at head
  logic [routerPkg::LEN_W-1:0] count;   // Cycles held so far

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      quantum <= '0;
      count   <= '0;
    end
    else
    begin
      if (headKind == routerPkg::FLIT_HEAD)
        quantum <= length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0; // Restart on every new grant
    end
  end

  // Holding ends on the cycle the count reaches the quantum
  assign timesUp = (count == quantum);

endmodule

// ==== design/routerPkg.sv ====
package routerPkg;

  // ********************
  // Widths and sizes
  // ********************
  localparam int DATA_W    = 16;
  localparam int LEN_W     = 12; // Quantum field in header payload
  localparam int NUM_PORTS = 5;

  // ********************
  // Encodings
  // ********************
  typedef enum logic [2:0]
  {
    PORT_L,
    PORT_N,
    PORT_E,
    PORT_W,
    PORT_S
  } portT;

  typedef enum logic [2:0]
  {
    FLIT_NONE = 3'd0,
    FLIT_HEAD = 3'd1,
    FLIT_BODY = 3'd2,
    FLIT_TAIL = 3'd3
  } flitKindT;

  typedef enum logic [5:0]
  {
    ARB_IDLE = 6'b000001,
    ARB_L    = 6'b000010,
    ARB_N    = 6'b000100,
    ARB_E    = 6'b001000,
    ARB_W    = 6'b010000,
    ARB_S    = 6'b100000
  } arbStateT;

  // Grant state that owns a given port
  function automatic arbStateT portGrant(input portT port);
    return arbStateT'(6'b000010 << port);
  endfunction

  function automatic portT grantPort(input arbStateT grant);
    portT port;
    case (grant)
      ARB_N:   port = PORT_N;
      ARB_E:   port = PORT_E;
      ARB_W:   port = PORT_W;
      ARB_S:   port = PORT_S;
      default: port = PORT_L; // Idle falls here too
    endcase
    return port;
  endfunction

endpackage

// ==== design/switchOutput.sv ====
module switchOutput
(
  input  logic                         clk,
  input  logic                         rst,
  input  routerPkg::arbStateT          grant,
  flitIntf.sink                        src [routerPkg::NUM_PORTS],
  output logic                         outValid,
  output logic [routerPkg::DATA_W-1:0] outData,
  output routerPkg::flitKindT          outKind,
  output routerPkg::portT              outPort
);

  logic [routerPkg::DATA_W-1:0]    headData [routerPkg::NUM_PORTS];
  routerPkg::flitKindT             headKind [routerPkg::NUM_PORTS];
  logic [routerPkg::NUM_PORTS-1:0] popVec;
  routerPkg::portT                 selPort;

  assign selPort = routerPkg::grantPort(grant);

  // ********************
  // Source select and pop
  // ********************
  for (genvar i = 0; i < routerPkg::NUM_PORTS; i++)
  begin : gSrc
    assign headData[i] = src[i].headData;
    assign headKind[i] = src[i].headKind;
    assign popVec[i]   = (grant == routerPkg::portGrant(routerPkg::portT'(i)))
                         && src[i].notEmpty;
    assign src[i].pop  = popVec[i];
  end

  // ********************
  // Output link register
  // ********************
  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |popVec; // At most one bit set
  end

  always_ff @(posedge clk)
  begin
    if (|popVec)
    begin
      outData <= headData[selPort];
      outKind <= headKind[selPort];
      outPort <= selPort;
    end
  end

endmodule

// ==== nocSwitch.f ====
design/routerPkg.sv
design/flitIntf.sv
design/inputQueue.sv
design/portTimer.sv
design/portArbiter.sv
design/switchOutput.sv
design/nocSwitch.sv
sim/nocSwitchTb.sv

// ==== sim/nocSwitchTb.sv ====
module nocSwitchTb;

  localparam int NP      = routerPkg::NUM_PORTS;
  localparam int FW      = routerPkg::DATA_W + 3; // Kind above data
  localparam int DEPTH   = 8;  // Queue depth set on the DUT
  localparam int ENTRIES = 12;
  localparam int SETTLED = 4;  // Pending cycles before the arbiter must see a port
  localparam int DRAIN   = 20; // Idle cycles watched after the last flit

  typedef struct packed
  {
    routerPkg::portT port;
    int              len;
    int              flits;
    int              start;
  } stimT;

  // Port, header length, flit count, start cycle
  // Each port keeps one length so its quantum stays steady
  localparam stimT STIM [ENTRIES] = '{
    '{routerPkg::PORT_L, 3,  6,   0}, // Lone port
    '{routerPkg::PORT_N, 2, 10,  30}, // All five contend
    '{routerPkg::PORT_E, 4, 12,  30},
    '{routerPkg::PORT_W, 1,  8,  30},
    '{routerPkg::PORT_S, 5, 10,  30},
    '{routerPkg::PORT_L, 3,  9,  32},
    '{routerPkg::PORT_E, 4,  6, 120},
    '{routerPkg::PORT_S, 5, 14, 121},
    '{routerPkg::PORT_N, 2,  4, 124},
    '{routerPkg::PORT_L, 3, 20, 170}, // Long packets fill the queues
    '{routerPkg::PORT_W, 1, 20, 170},
    '{routerPkg::PORT_N, 2, 16, 171}
  };

  logic                         clk;
  logic                         rst;
  logic                         inValid [NP];
  logic [routerPkg::DATA_W-1:0] inData  [NP];
  routerPkg::flitKindT          inKind  [NP];
  logic                         inFull  [NP];
  logic                         outValid;
  logic [routerPkg::DATA_W-1:0] outData;
  routerPkg::flitKindT          outKind;
  routerPkg::portT              outPort;

  logic [31:0]     lfsr;
  logic [FW-1:0]   expQ [NP][$]; // Scoreboard per source port
  int              jobQ [NP][$]; // Table entries waiting per port
  int              curEntry  [NP];
  int              flitIdx   [NP];
  logic            wrotePrev [NP];
  logic            fullSeen  [NP];
  int              pendAge   [NP];
  int              latestLen [NP];
  int              cycle;
  int              limit;
  int              maxStart;
  int              totalFlits;
  int              outCount;
  int              runLen;
  int              gapCycles;
  int              valueErrs;
  int              otherErrs;
  routerPkg::portT lastPort;
  logic            timedOut;

  nocSwitch
  #(
    .DEPTH (DEPTH)
  )
  DUT
  (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inData   (inData),
    .inKind   (inKind),
    .inFull   (inFull),
    .outValid (outValid),
    .outData  (outData),
    .outKind  (outKind),
    .outPort  (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ********************
  // Stimulus helpers
  // ********************
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hD000_0001;
    return s >> 1;
  endfunction

  function automatic logic [routerPkg::DATA_W-1:0] randomWord();
    logic [routerPkg::DATA_W-1:0] w;
    w = '0;
    for (int b = 0; b < routerPkg::DATA_W; b++)
    begin
      w    = {w[routerPkg::DATA_W-2:0], lfsr[0]};
      lfsr = lfsrStep(lfsr); // One step per bit
    end
    return w;
  endfunction

  function automatic logic [FW-1:0] makeFlit(input int e, input int idx);
    routerPkg::flitKindT          kind;
    logic [routerPkg::DATA_W-1:0] data;
    if (idx == 0)
    begin
      kind = routerPkg::FLIT_HEAD;
      data = {1'b0, STIM[e].port, routerPkg::LEN_W'(STIM[e].len)}; // Length in low bits
    end
    else
    begin
      kind = (idx == STIM[e].flits - 1) ? routerPkg::FLIT_TAIL : routerPkg::FLIT_BODY;
      data = randomWord();
    end
    return {kind, data};
  endfunction

  // Called on the rising edge; a port writes at most every other cycle
  task driveInputs;
    logic [FW-1:0] flit;
    for (int p = 0; p < NP; p++)
    begin
      if (curEntry[p] < 0 && jobQ[p].size() > 0 && STIM[jobQ[p][0]].start <= cycle)
      begin
        curEntry[p] = jobQ[p].pop_front();
        flitIdx[p]  = 0;
      end
      if (curEntry[p] >= 0 && !wrotePrev[p] && !fullSeen[p])
      begin
        flit = makeFlit(curEntry[p], flitIdx[p]);
        inValid[p]   <= 1'b1;
        inData[p]    <= flit[routerPkg::DATA_W-1:0];
        inKind[p]    <= routerPkg::flitKindT'(flit[FW-1:routerPkg::DATA_W]);
        expQ[p].push_back(flit);
        wrotePrev[p] = 1'b1;
        flitIdx[p]++;
        if (flitIdx[p] == STIM[curEntry[p]].flits)
          curEntry[p] = -1;
      end
      else
      begin
        inValid[p]   <= 1'b0;
        wrotePrev[p] = 1'b0;
      end
    end
    cycle++;
  endtask

  // ********************
  // Output checks
  // ********************
  task checkOutputs;
    logic [FW-1:0]   exp;
    routerPkg::portT q;
    routerPkg::portT expPort;
    logic            found;
    logic            othersPending;
    int              r;
    int              occupancy;
    if (outValid)
    begin
      q = outPort;
      assert (expQ[q].size() > 0)
      else
      begin
        otherErrs++;
        $display("Output flit tagged port %0d while nothing is pending there", q);
      end
      if (expQ[q].size() > 0)
      begin
        // Gap of at most one cycle means a direct hand-over, not a pass through idle
        if (gapCycles <= 1 && q != lastPort)
        begin
          found   = 1'b0;
          expPort = q;
          for (int k = 1; k < NP; k++)
          begin
            r = (int'(lastPort) + k) % NP;
            if (!found && (r == int'(q) || pendAge[r] >= SETTLED))
            begin
              found   = 1'b1;
              expPort = routerPkg::portT'(r);
            end
          end
          assert (expPort == q)
          else
          begin
            valueErrs++;
            $display("FAILED rotation after port %0d: expected %0d, actual %0d",
                     lastPort, expPort, q);
          end
        end
        exp = expQ[q].pop_front();
        assert (outData == exp[routerPkg::DATA_W-1:0])
        else
        begin
          valueErrs++;
          $display("FAILED data port %0d: expected %h, actual %h",
                   q, exp[routerPkg::DATA_W-1:0], outData);
        end
        assert (outKind == routerPkg::flitKindT'(exp[FW-1:routerPkg::DATA_W]))
        else
        begin
          valueErrs++;
          $display("FAILED kind port %0d: expected %0d, actual %0d",
                   q, exp[FW-1:routerPkg::DATA_W], outKind);
        end
        if (routerPkg::flitKindT'(exp[FW-1:routerPkg::DATA_W]) == routerPkg::FLIT_HEAD)
          latestLen[q] = int'(exp[routerPkg::LEN_W-1:0]);
        runLen = (gapCycles == 0 && q == lastPort) ? runLen + 1 : 1;
        othersPending = 1'b0;
        for (int p = 0; p < NP; p++)
          if (p != int'(q) && expQ[p].size() > 0)
            othersPending = 1'b1;
        if (othersPending)
          assert (runLen <= latestLen[q] + 1)
          else
          begin
            valueErrs++;
            $display("FAILED quantum port %0d: expected at most %0d, actual %0d",
                     q, latestLen[q] + 1, runLen);
          end
        outCount++;
      end
      lastPort  = q;
      gapCycles = 0;
    end
    else
      gapCycles++;

    for (int p = 0; p < NP; p++)
    begin
      occupancy = expQ[p].size() - (wrotePrev[p] ? 1 : 0); // Latest drive not written yet
      assert (inFull[p] == (occupancy == DEPTH))
      else
      begin
        valueErrs++;
        $display("FAILED full level port %0d: expected %0b, actual %0b",
                 p, occupancy == DEPTH, inFull[p]);
      end
      fullSeen[p] = inFull[p];
      pendAge[p]  = (expQ[p].size() > 0) ? pendAge[p] + 1 : 0;
    end
  endtask

  // ********************
  // Main sequence
  // ********************
  initial
  begin
    rst        = 1'b1;
    lfsr       = 32'h38b9_b764;
    cycle      = 0;
    maxStart   = 0;
    totalFlits = 0;
    outCount   = 0;
    runLen     = 0;
    gapCycles  = 100;
    valueErrs  = 0;
    otherErrs  = 0;
    lastPort   = routerPkg::PORT_L;
    timedOut   = 1'b0;
    for (int p = 0; p < NP; p++)
    begin
      inValid[p]   = 1'b0;
      inData[p]    = '0;
      inKind[p]    = routerPkg::FLIT_NONE;
      curEntry[p]  = -1;
      flitIdx[p]   = 0;
      wrotePrev[p] = 1'b0;
      fullSeen[p]  = 1'b0;
      pendAge[p]   = 0;
      latestLen[p] = 0;
    end
    for (int e = 0; e < ENTRIES; e++)
    begin
      jobQ[STIM[e].port].push_back(e);
      totalFlits += STIM[e].flits;
      if (STIM[e].start > maxStart)
        maxStart = STIM[e].start;
    end
    limit = maxStart + 2 * totalFlits + 100; // Inputs run at half rate

    for (int i = 0; i < 2; i++)
    begin
      @(posedge clk);
      if (i == 1)
        rst <= 1'b0;
      @(negedge clk);
      assert (outValid == 1'b0)
      else
      begin
        otherErrs++;
        $display("Output valid raised during reset");
      end
    end

    while (outCount < totalFlits && !timedOut)
    begin
      @(posedge clk);
      driveInputs();
      @(negedge clk);
      checkOutputs();
      if (cycle >= limit)
        timedOut = 1'b1;
    end
    assert (!timedOut)
    else
    begin
      otherErrs++;
      $display("Timed out after %0d cycles with %0d of %0d flits delivered",
               cycle, outCount, totalFlits);
    end

    if (!timedOut)
      repeat (DRAIN)
      begin
        @(posedge clk);
        driveInputs();
        @(negedge clk);
        checkOutputs();
      end

    for (int p = 0; p < NP; p++)
      assert (expQ[p].size() == 0)
      else
      begin
        otherErrs++;
        $display("%0d undelivered flits left on port %0d", expQ[p].size(), p);
      end

    $display("Errors: %0d wrong values, %0d other failures", valueErrs, otherErrs);
    if (valueErrs == 0 && otherErrs == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
